//--- lsu_conf_pkg.sv
package lsu_conf_pkg;

  // ----------------------------------------------------------
  // address and register widths
  // ----------------------------------------------------------
  localparam int paddr_w = 32;
  localparam int xlen_w  = 64;

  // ----------------------------------------------------------
  // cache-line geometry
  // ----------------------------------------------------------
  localparam int line_w     = 128;
  localparam int line_b_w   = line_w / 8;        // bytes per line
  localparam int line_off_w = $clog2(line_b_w);  // byte offset bits

  typedef logic [paddr_w-1:0]  paddr_t;
  typedef logic [xlen_w-1:0]   xlen_t;
  typedef logic [line_w-1:0]   line_t;
  typedef logic [line_b_w-1:0] line_be_t;

  // address with the byte offset stripped
  typedef logic [paddr_w-line_off_w-1:0] line_addr_t;

  // two addresses hit the same line when these match
  function automatic line_addr_t line_addr(paddr_t addr);
    return addr[paddr_w-1:line_off_w];
  endfunction

endpackage

//--- lsu_bus_pkg.sv
package lsu_bus_pkg;

  // ----------------------------------------------------------
  // uncached store size, as sent by the lsu pipeline
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    size_b  = 2'b00,
    size_h  = 2'b01,
    size_w  = 2'b10,
    size_dw = 2'b11
  } st_size_t;

  // ----------------------------------------------------------
  // l2 request tag
  // ----------------------------------------------------------
  localparam int l2_tag_w = 8;
  localparam int l2_src_w = 2;  // source code sits in the top bits

  typedef logic [l2_src_w-1:0] l2_src_t;
  typedef logic [l2_tag_w-1:0] l2_tag_t;

  localparam l2_src_t src_evict = 2'b10;  // dirty line from l1d
  localparam l2_src_t src_uc    = 2'b11;  // uncached store

  // lower tag bits stay zero, one request per source in flight
  function automatic l2_tag_t make_tag(l2_src_t src);
    return {src, {(l2_tag_w-l2_src_w){1'b0}}};
  endfunction

  // line leaving the l1d
  typedef struct packed {
    lsu_conf_pkg::paddr_t paddr;
    lsu_conf_pkg::line_t  data;
  } evict_payload_t;

endpackage

//--- lsu_store_ifs.sv
`timescale 1ns/1ps

// l1d eviction into the store-out stage
interface evict_if;
  import lsu_bus_pkg::*;

  logic           valid;
  logic           ready;
  evict_payload_t payload;

  modport master (output valid, output payload, input ready);
  modport slave  (input valid, input payload, output ready);
endinterface

// uncached store from the lsu pipeline
interface uc_write_if;
  import lsu_conf_pkg::*;
  import lsu_bus_pkg::*;

  logic     valid;
  logic     ready;
  paddr_t   paddr;
  xlen_t    data;
  st_size_t size;

  modport master (output valid, output paddr, output data, output size, input ready);
  modport slave  (input valid, input paddr, input data, input size, output ready);
endinterface

// one load lane probing the pending eviction, no handshake
interface fwd_check_if;
  import lsu_conf_pkg::*;

  logic   valid;
  paddr_t paddr;
  logic   fwd_valid;
  xlen_t  fwd_data;

  modport master (output valid, output paddr, input fwd_valid, input fwd_data);
  modport slave  (input valid, input paddr, output fwd_valid, output fwd_data);
endinterface

// coherence snoop, answer one cycle after the strobe
interface snoop_if;
  import lsu_conf_pkg::*;

  logic   req_valid;
  paddr_t req_paddr;
  logic   resp_valid;
  logic   resp_hit;
  line_t  resp_data;

  modport master (output req_valid, output req_paddr,
                  input resp_valid, input resp_hit, input resp_data);
  modport slave  (input req_valid, input req_paddr,
                  output resp_valid, output resp_hit, output resp_data);
endinterface

// write request towards the l2
interface l2_wr_req_if;
  import lsu_conf_pkg::*;
  import lsu_bus_pkg::*;

  logic     valid;
  logic     ready;
  paddr_t   addr;
  l2_tag_t  tag;
  line_t    data;
  line_be_t byte_en;

  modport master (output valid, output addr, output tag, output data, output byte_en,
                  input ready);
  modport slave  (input valid, input addr, input tag, input data, input byte_en,
                  output ready);
endinterface

//--- store_fwd_checker.sv
`timescale 1ns/1ps

module store_fwd_checker (
  input logic                        i_clk,
  input logic                        i_reset_n,

  fwd_check_if.slave                 lane,

  // eviction register contents
  input logic                        i_evict_valid,
  input lsu_bus_pkg::evict_payload_t i_evict_payload
);
  import lsu_conf_pkg::*;

  logic  same_line;
  line_t shifted_line;

  assign same_line = line_addr(lane.paddr) == line_addr(i_evict_payload.paddr);

  // hit only while the line still waits for the l2
  assign lane.fwd_valid = lane.valid & i_evict_valid & same_line;

  // byte offset turned into a bit shift
  assign shifted_line  = i_evict_payload.data >> {lane.paddr[line_off_w-1:0], 3'b000};
  assign lane.fwd_data = shifted_line[xlen_w-1:0];  // load sees the low dword

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // forwarded line must not move while still pending
  a_evict_line_stable: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_evict_valid |=> !i_evict_valid || $stable(i_evict_payload)
  ) else $error("pending eviction line changed while still held");

endmodule

//--- store_requestor.sv
`timescale 1ns/1ps

module store_requestor #(
  parameter int lane_num = 2
) (
  input logic         i_clk,
  input logic         i_reset_n,

  evict_if.slave      evict,
  uc_write_if.slave   uc_write,

  fwd_check_if.slave  fwd_check [lane_num],  // one per load lane
  snoop_if.slave      snoop,

  l2_wr_req_if.master l2_req
);
  import lsu_conf_pkg::*;
  import lsu_bus_pkg::*;

  localparam l2_tag_t tag_evict = make_tag(src_evict);
  localparam l2_tag_t tag_uc    = make_tag(src_uc);

  logic           r_evict_valid;
  evict_payload_t r_evict_payload;

  logic           r_uc_valid;
  paddr_t         r_uc_paddr;
  xlen_t          r_uc_data;
  line_be_t       r_uc_be;
  line_be_t       uc_be_next;

  logic           sel_uc;       // arbiter picks the uncached store
  logic           r_uc_locked;  // uc request shown but not taken yet
  logic           l2_fire;

  logic           r_snoop_hit;
  line_t          r_snoop_data;

  assign l2_fire = l2_req.valid & l2_req.ready;

  // ------------------------------------------------------------
  // eviction holding register
  // ------------------------------------------------------------
  assign evict.ready = !r_evict_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_evict_valid <= 1'b0;
    end else if (evict.valid & evict.ready) begin
      r_evict_valid <= 1'b1;
    end else if (l2_fire & !sel_uc) begin
      r_evict_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (evict.valid & evict.ready) begin
      r_evict_payload <= evict.payload;
    end
  end

  // ------------------------------------------------------------
  // uncached store holding register
  // ------------------------------------------------------------
  assign uc_write.ready = !r_uc_valid;

  always_comb begin
    uc_be_next = '0;
    unique case (uc_write.size)
      size_b:  uc_be_next = line_be_t'(8'h01);
      size_h:  uc_be_next = line_be_t'(8'h03);
      size_w:  uc_be_next = line_be_t'(8'h0f);
      size_dw: uc_be_next = line_be_t'(8'hff);
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_uc_valid <= 1'b0;
    end else if (uc_write.valid & uc_write.ready) begin
      r_uc_valid <= 1'b1;
    end else if (l2_fire & sel_uc) begin
      r_uc_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (uc_write.valid & uc_write.ready) begin
      r_uc_paddr <= uc_write.paddr;
      r_uc_data  <= uc_write.data;
      r_uc_be    <= uc_be_next;
    end
  end

  // ------------------------------------------------------------
  // arbiter and l2 request mux
  // ------------------------------------------------------------
  // eviction first, unless a uc request is already stalled on the port
  assign sel_uc = r_uc_valid & (r_uc_locked | !r_evict_valid);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_uc_locked <= 1'b0;
    end else begin
      r_uc_locked <= sel_uc & !l2_req.ready;
    end
  end

  always_comb begin
    l2_req.valid = r_evict_valid | r_uc_valid;
    if (sel_uc) begin
      l2_req.addr    = r_uc_paddr;
      l2_req.tag     = tag_uc;
      l2_req.data    = {{(line_w-xlen_w){1'b0}}, r_uc_data};  // low dword of the line
      l2_req.byte_en = r_uc_be;
    end else begin
      l2_req.addr    = r_evict_payload.paddr;
      l2_req.tag     = tag_evict;
      l2_req.data    = r_evict_payload.data;
      l2_req.byte_en = '1;  // whole line
    end
  end

  // ------------------------------------------------------------
  // snoop checker
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      snoop.resp_valid <= 1'b0;
      r_snoop_hit      <= 1'b0;
    end else begin
      snoop.resp_valid <= snoop.req_valid;
      r_snoop_hit      <= snoop.req_valid & r_evict_valid &
                          (line_addr(snoop.req_paddr) == line_addr(r_evict_payload.paddr));
    end
  end

  always_ff @(posedge i_clk) begin
    if (snoop.req_valid) begin
      r_snoop_data <= r_evict_payload.data;  // line as held in the request cycle
    end
  end

  assign snoop.resp_hit  = r_snoop_hit;
  assign snoop.resp_data = r_snoop_data;

  // ------------------------------------------------------------
  // forward checkers, one per load lane
  // ------------------------------------------------------------
  generate
    for (genvar g = 0; g < lane_num; g++) begin : g_fwd
      store_fwd_checker store_fwd_checker_inst (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .lane            (fwd_check[g]),
        .i_evict_valid   (r_evict_valid),
        .i_evict_payload (r_evict_payload)
      );
    end
  endgenerate

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_l2_stable: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    l2_req.valid && !l2_req.ready |=>
      l2_req.valid && $stable(l2_req.addr) && $stable(l2_req.tag) &&
      $stable(l2_req.data) && $stable(l2_req.byte_en)
  ) else $error("l2 request changed under back-pressure");

  // held uc store frees its slot only through an l2 transfer tagged uc
  a_uc_ready_held: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !uc_write.ready && !(l2_fire && l2_req.tag == tag_uc) |=> !uc_write.ready
  ) else $error("uc ready rose while the store was still held");

endmodule

//--- lsu_store_out_top.sv
`timescale 1ns/1ps

module lsu_store_out_top #(
  parameter int lane_num = 2
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,

  // l1d eviction
  input  logic                                i_evict_valid,
  output logic                                o_evict_ready,
  input  lsu_conf_pkg::paddr_t                i_evict_paddr,
  input  lsu_conf_pkg::line_t                 i_evict_data,

  // uncached store
  input  logic                                i_uc_valid,
  output logic                                o_uc_ready,
  input  lsu_conf_pkg::paddr_t                i_uc_paddr,
  input  lsu_conf_pkg::xlen_t                 i_uc_data,
  input  lsu_bus_pkg::st_size_t               i_uc_size,

  // load lane forwarding
  input  logic [lane_num-1:0]                 i_fwd_valid,
  input  lsu_conf_pkg::paddr_t [lane_num-1:0] i_fwd_paddr,
  output logic [lane_num-1:0]                 o_fwd_valid,
  output lsu_conf_pkg::xlen_t [lane_num-1:0]  o_fwd_data,

  // snoop
  input  logic                                i_snoop_req_valid,
  input  lsu_conf_pkg::paddr_t                i_snoop_req_paddr,
  output logic                                o_snoop_resp_valid,
  output logic                                o_snoop_resp_hit,
  output lsu_conf_pkg::line_t                 o_snoop_resp_data,

  // l2 write request
  output logic                                o_l2_valid,
  input  logic                                i_l2_ready,
  output lsu_conf_pkg::paddr_t                o_l2_addr,
  output lsu_bus_pkg::l2_tag_t                o_l2_tag,
  output lsu_conf_pkg::line_t                 o_l2_data,
  output lsu_conf_pkg::line_be_t              o_l2_byte_en
);

  evict_if     evict_bus ();
  uc_write_if  uc_bus ();
  fwd_check_if fwd_bus [lane_num] ();
  snoop_if     snoop_bus ();
  l2_wr_req_if l2_bus ();

  // ------------------------------------------------------------
  // ports onto interfaces
  // ------------------------------------------------------------
  assign evict_bus.valid   = i_evict_valid;
  assign evict_bus.payload = '{paddr: i_evict_paddr, data: i_evict_data};
  assign o_evict_ready     = evict_bus.ready;

  assign uc_bus.valid = i_uc_valid;
  assign uc_bus.paddr = i_uc_paddr;
  assign uc_bus.data  = i_uc_data;
  assign uc_bus.size  = i_uc_size;
  assign o_uc_ready   = uc_bus.ready;

  generate
    for (genvar g = 0; g < lane_num; g++) begin : g_lane
      assign fwd_bus[g].valid = i_fwd_valid[g];
      assign fwd_bus[g].paddr = i_fwd_paddr[g];
      assign o_fwd_valid[g]   = fwd_bus[g].fwd_valid;
      assign o_fwd_data[g]    = fwd_bus[g].fwd_data;
    end
  endgenerate

  assign snoop_bus.req_valid = i_snoop_req_valid;
  assign snoop_bus.req_paddr = i_snoop_req_paddr;
  assign o_snoop_resp_valid  = snoop_bus.resp_valid;
  assign o_snoop_resp_hit    = snoop_bus.resp_hit;
  assign o_snoop_resp_data   = snoop_bus.resp_data;

  assign l2_bus.ready = i_l2_ready;
  assign o_l2_valid   = l2_bus.valid;
  assign o_l2_addr    = l2_bus.addr;
  assign o_l2_tag     = l2_bus.tag;
  assign o_l2_data    = l2_bus.data;
  assign o_l2_byte_en = l2_bus.byte_en;

  store_requestor #(
    .lane_num (lane_num)
  ) store_requestor_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .evict     (evict_bus),
    .uc_write  (uc_bus),
    .fwd_check (fwd_bus),
    .snoop     (snoop_bus),
    .l2_req    (l2_bus)
  );

endmodule

//--- tb_lsu_store_out.sv
`timescale 1ns/1ps

module tb_lsu_store_out #(
  parameter int lane_num = 2
);
  import lsu_conf_pkg::*;
  import lsu_bus_pkg::*;

  typedef struct {
    paddr_t   addr;
    l2_tag_t  tag;
    line_t    data;
    line_be_t be;
  } l2_wr_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_evict_valid;
  logic                  o_evict_ready;
  paddr_t                i_evict_paddr;
  line_t                 i_evict_data;
  logic                  i_uc_valid;
  logic                  o_uc_ready;
  paddr_t                i_uc_paddr;
  xlen_t                 i_uc_data;
  st_size_t              i_uc_size;
  logic [lane_num-1:0]   i_fwd_valid;
  paddr_t [lane_num-1:0] i_fwd_paddr;
  logic [lane_num-1:0]   o_fwd_valid;
  xlen_t [lane_num-1:0]  o_fwd_data;
  logic                  i_snoop_req_valid;
  paddr_t                i_snoop_req_paddr;
  logic                  o_snoop_resp_valid;
  logic                  o_snoop_resp_hit;
  line_t                 o_snoop_resp_data;
  logic                  o_l2_valid;
  logic                  i_l2_ready;
  paddr_t                o_l2_addr;
  l2_tag_t               o_l2_tag;
  line_t                 o_l2_data;
  line_be_t              o_l2_byte_en;

  l2_wr_t exp_q[$];          // writes the dut still owes the l2
  string  stim_q[$];
  int     n_ops    = 0;
  integer seed     = 32'hd5f77804;
  logic   throttle = 1'b0;   // random l2 ready only while idling

  lsu_store_out_top #(
    .lane_num (lane_num)
  ) lsu_store_out_top_inst (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_evict_valid (i_evict_valid), .o_evict_ready (o_evict_ready),
    .i_evict_paddr (i_evict_paddr), .i_evict_data (i_evict_data),
    .i_uc_valid (i_uc_valid), .o_uc_ready (o_uc_ready), .i_uc_paddr (i_uc_paddr),
    .i_uc_data (i_uc_data), .i_uc_size (i_uc_size),
    .i_fwd_valid (i_fwd_valid), .i_fwd_paddr (i_fwd_paddr),
    .o_fwd_valid (o_fwd_valid), .o_fwd_data (o_fwd_data),
    .i_snoop_req_valid (i_snoop_req_valid), .i_snoop_req_paddr (i_snoop_req_paddr),
    .o_snoop_resp_valid (o_snoop_resp_valid), .o_snoop_resp_hit (o_snoop_resp_hit),
    .o_snoop_resp_data (o_snoop_resp_data),
    .o_l2_valid (o_l2_valid), .i_l2_ready (i_l2_ready), .o_l2_addr (o_l2_addr),
    .o_l2_tag (o_l2_tag), .o_l2_data (o_l2_data), .o_l2_byte_en (o_l2_byte_en)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ------------------------------------------------------------
  // error reporting and compare tasks
  // ------------------------------------------------------------
  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string sig, string exp_s, string act_s);
    stop_on_error($sformatf("[FAIL] time %0t %s expected %s actual %s",
                            $time, sig, exp_s, act_s));
  endtask

  task automatic check_bit(string sig, logic exp_v, logic act_v);
    if (act_v !== exp_v) report_mismatch(sig, $sformatf("%b", exp_v), $sformatf("%b", act_v));
  endtask

  task automatic check_l2_req(lsu_conf_pkg::paddr_t exp_addr, lsu_bus_pkg::l2_tag_t exp_tag,
                              lsu_conf_pkg::line_t exp_data, lsu_conf_pkg::line_be_t exp_be);
    if (o_l2_addr !== exp_addr)
      report_mismatch("o_l2_addr", $sformatf("%h", exp_addr), $sformatf("%h", o_l2_addr));
    if (o_l2_tag !== exp_tag)
      report_mismatch("o_l2_tag", $sformatf("%h", exp_tag), $sformatf("%h", o_l2_tag));
    if (o_l2_data !== exp_data)
      report_mismatch("o_l2_data", $sformatf("%h", exp_data), $sformatf("%h", o_l2_data));
    if (o_l2_byte_en !== exp_be)
      report_mismatch("o_l2_byte_en", $sformatf("%h", exp_be), $sformatf("%h", o_l2_byte_en));
  endtask

  task automatic check_fwd(int lane, logic exp_hit, lsu_conf_pkg::xlen_t exp_data);
    check_bit($sformatf("o_fwd_valid[%0d]", lane), exp_hit, o_fwd_valid[lane]);
    if (exp_hit && o_fwd_data[lane] !== exp_data)
      report_mismatch($sformatf("o_fwd_data[%0d]", lane), $sformatf("%h", exp_data),
                      $sformatf("%h", o_fwd_data[lane]));
  endtask

  task automatic check_snoop(logic exp_hit, lsu_conf_pkg::line_t exp_data);
    check_bit("o_snoop_resp_valid", 1'b1, o_snoop_resp_valid);
    check_bit("o_snoop_resp_hit", exp_hit, o_snoop_resp_hit);
    if (exp_hit && o_snoop_resp_data !== exp_data)
      report_mismatch("o_snoop_resp_data", $sformatf("%h", exp_data),
                      $sformatf("%h", o_snoop_resp_data));
  endtask

  // low-aligned enable for 1, 2, 4 or 8 bytes
  function automatic line_be_t size_to_byte_en(int size);
    case (size)
      0:       return line_be_t'(16'h0001);
      1:       return line_be_t'(16'h0003);
      2:       return line_be_t'(16'h000f);
      default: return line_be_t'(16'h00ff);
    endcase
  endfunction

  task automatic advance_cycle();
    @(posedge i_clk);
    #1;
    i_l2_ready = throttle && (($random(seed) & 3) != 0);
  endtask

  // peek at the oldest expected write every cycle, pop it on transfer
  always @(negedge i_clk) begin
    if (i_reset_n && o_l2_valid) begin
      if (exp_q.size() == 0) begin
        stop_on_error("the l2 port requested a write that no stimulus line asked for");
      end else begin
        check_l2_req(exp_q[0].addr, exp_q[0].tag, exp_q[0].data, exp_q[0].be);
        if (i_l2_ready) void'(exp_q.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // one stimulus line
  // ------------------------------------------------------------
  task automatic run_op(string txt);
    byte    op;
    paddr_t addr;
    line_t  line_v;
    xlen_t  dword;
    int     lane;
    int     num;
    int     hit;
    op = txt.getc(0);
    case (op)
      "E": begin
        void'($sscanf(txt, "%c %h %h", op, addr, line_v));
        while (!o_evict_ready) advance_cycle();
        i_evict_valid = 1'b1;
        i_evict_paddr = addr;
        i_evict_data  = line_v;
        exp_q.push_back('{addr, {2'b10, 6'b0}, line_v, {line_b_w{1'b1}}});
        advance_cycle();
        i_evict_valid = 1'b0;
        check_bit("o_l2_valid", 1'b1, o_l2_valid);  // one cycle after accept
      end
      "U": begin
        void'($sscanf(txt, "%c %h %h %d", op, addr, dword, num));
        while (!o_uc_ready) advance_cycle();
        i_uc_valid = 1'b1;
        i_uc_paddr = addr;
        i_uc_data  = dword;
        i_uc_size  = st_size_t'(num);
        exp_q.push_back('{addr, {2'b11, 6'b0}, {64'h0, dword}, size_to_byte_en(num)});
        advance_cycle();
        i_uc_valid = 1'b0;
        check_bit("o_l2_valid", 1'b1, o_l2_valid);
      end
      "F": begin
        void'($sscanf(txt, "%c %d %h %d %h", op, lane, addr, hit, dword));
        i_fwd_valid[lane] = 1'b1;
        i_fwd_paddr[lane] = addr;
        @(negedge i_clk);
        check_fwd(lane, hit[0], dword);
        advance_cycle();
        i_fwd_valid[lane] = 1'b0;
      end
      "S": begin
        void'($sscanf(txt, "%c %h %d %h", op, addr, hit, line_v));
        i_snoop_req_valid = 1'b1;
        i_snoop_req_paddr = addr;
        advance_cycle();
        i_snoop_req_valid = 1'b0;
        check_snoop(hit[0], line_v);
        advance_cycle();
        check_bit("o_snoop_resp_valid", 1'b0, o_snoop_resp_valid);
      end
      "W": begin
        void'($sscanf(txt, "%c %d", op, num));
        throttle = 1'b1;
        repeat (num) advance_cycle();
        while (exp_q.size() != 0) advance_cycle();  // drain the l2 queue
        throttle   = 1'b0;
        i_l2_ready = 1'b0;
      end
      default: stop_on_error($sformatf("unknown operation in stimulus line: %s", txt));
    endcase
  endtask

  // ------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    int    fd;
    string txt;
    i_reset_n = 1'b0;
    i_evict_valid = 1'b0;
    i_evict_paddr = '0;
    i_evict_data = '0;
    i_uc_valid = 1'b0;
    i_uc_paddr = '0;
    i_uc_data = '0;
    i_uc_size = size_b;
    i_fwd_valid = '0;
    i_fwd_paddr = '0;
    i_snoop_req_valid = 1'b0;
    i_snoop_req_paddr = '0;
    i_l2_ready = 1'b0;
    fd = $fopen("store_stim.txt", "r");
    if (fd == 0) stop_on_error("could not open the stimulus file store_stim.txt");
    while ($fgets(txt, fd) != 0) begin
      if (txt.len() > 1 && txt.getc(0) != "#") stim_q.push_back(txt);
    end
    $fclose(fd);
    n_ops = stim_q.size();
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    check_bit("o_l2_valid", 1'b0, o_l2_valid);
    check_bit("o_snoop_resp_valid", 1'b0, o_snoop_resp_valid);
    check_bit("o_evict_ready", 1'b1, o_evict_ready);
    check_bit("o_uc_ready", 1'b1, o_uc_ready);
    foreach (stim_q[i]) run_op(stim_q[i]);
    if (exp_q.size() != 0) begin
      stop_on_error("expected l2 writes were never sent");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  initial begin
    wait (n_ops > 0);
    repeat (16 + n_ops * 200) @(posedge i_clk);
    stop_on_error("watchdog expired, the stimulus did not finish in time");
  end

endmodule

//--- store_stim.txt
# E paddr line | U paddr data size(0..3) | F lane paddr hit data
# S paddr hit line | W idle cycles, then wait until the l2 queue drains
# single eviction, forwarded to both lanes and snooped while pending
E 00001040 0f0e0d0c0b0a09080706050403020100
F 0 00001040 1 0706050403020100
F 1 00001048 1 0f0e0d0c0b0a0908
F 0 00001043 1 0a09080706050403
F 1 0000104c 1 000000000f0e0d0c
F 0 00001050 0 0
S 00001044 1 0f0e0d0c0b0a09080706050403020100
S 00002040 0 0
W 4
F 0 00001040 0 0
S 00001040 0 0
# uncached stores of every size
U 20000010 1122334455667788 0
W 2
U 20000018 1122334455667788 1
W 0
U 20000020 a5a5a5a5deadbeef 2
W 0
U 20000028 0123456789abcdef 3
W 1
# both held at once, eviction goes first
E 00003000 1f1e1d1c1b1a19181716151413121110
U 30000008 cafef00d12345678 3
F 1 0000300f 1 000000000000001f
S 0000300a 1 1f1e1d1c1b1a19181716151413121110
W 8
# uc store already stalled on the port keeps it
U 40000000 00000000000000ff 0
E 00004080 2f2e2d2c2b2a29282726252423222120
W 6
F 1 00004080 0 0

//--- src.f
lsu_conf_pkg.sv
lsu_bus_pkg.sv
lsu_store_ifs.sv
store_fwd_checker.sv
store_requestor.sv
lsu_store_out_top.sv
tb_lsu_store_out.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu_store_out -f src.f -o sim_tb

# the simulator exit code is not trusted, the log decides
./obj_dir/sim_tb | tee sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
